/* hw/bp_consts.svh */
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// ordered branch-history queue depth and tag width (log2 of depth)
`define OBQ_DEPTH 8
`define TAG_BITS 3

// speculative global history width
`define GHR_BITS 6

// gshare counter table, entries and index width
`define PHT_ENTRIES 64
`define PHT_IDX_BITS 6

// fetch address width
`define PC_BITS 32

`endif

/* hw/bp_pkg.sv */
`include "bp_consts.svh"

package bp_pkg;

	// two-bit saturating counter, upper bit is the predicted direction
	typedef enum logic [1:0] {
		CTR_SNT = 2'b00,
		CTR_WNT = 2'b01,
		CTR_WT  = 2'b10,
		CTR_ST  = 2'b11
	} ctr_t;

	// one queue row: history before the branch, table index, predicted direction
	typedef struct packed {
		logic [`GHR_BITS-1:0]     ghr;
		logic [`PHT_IDX_BITS-1:0] idx;
		logic                     taken;
	} obq_row_t;

	// owner of the table port
	typedef enum logic [1:0] {GNT_NONE, GNT_LOOKUP, GNT_RESOLVE} grant_t;

	// resolve path: wait for a branch, read its counter, write it back
	typedef enum logic [1:0] {RES_IDLE, RES_READ, RES_WRITE} res_state_t;

endpackage

/* hw/pht_bus_if.sv */
`timescale 1ns/10ps
`include "bp_consts.svh"

interface pht_bus_if;

	// request side, held until gnt
	logic                     req;
	logic                     we;
	logic [`PHT_IDX_BITS-1:0] addr;
	bp_pkg::ctr_t             wdata;

	// response side, rdata one cycle after gnt on a read
	logic                     gnt;
	bp_pkg::ctr_t             rdata;

	modport requester (output req, we, addr, wdata, input gnt, rdata);

	modport arbiter (input req, we, addr, wdata, output gnt, rdata);

endinterface

/* hw/obq.sv */
`timescale 1ns/10ps
`include "bp_consts.svh"

// oldest row sits at index 0 and the newest at tail-1
module obq (
	input  logic                                 clock,
	input  logic                                 reset,
	input  logic                                 write_en,
	input  logic                                 clear_en,
	input  logic [`TAG_BITS-1:0]                 index,
	input  bp_pkg::obq_row_t                     bh_row,
	output logic [`TAG_BITS:0]                   tail,
	output logic                                 bh_pred_valid,
	output bp_pkg::obq_row_t                     bh_pred,
	output logic                                 full,
	output bp_pkg::obq_row_t [`OBQ_DEPTH-1:0]    rows
);

	bp_pkg::obq_row_t [`OBQ_DEPTH-1:0] rows_next;
	logic [`TAG_BITS:0]                tail_next;

	assign full = (tail == `OBQ_DEPTH);
	assign bh_pred_valid = (tail != '0);

	// newest row or zero when the queue is empty
	assign bh_pred = bh_pred_valid ? rows[tail[`TAG_BITS-1:0] - 1'b1] : '0;

	always_comb begin
		rows_next = rows;
		tail_next = tail;
		if (clear_en) begin
			// drop the row at index and everything younger
			for (int i = 0; i < `OBQ_DEPTH; i++) begin
				if (i >= index) begin
					rows_next[i] = '0;
				end
			end
			tail_next = {1'b0, index};
			if (write_en) begin
				// rollback plus rewrite of the resolved branch
				rows_next[index] = bh_row;
				tail_next = {1'b0, index} + 1'b1;
			end
		end else if (write_en && !full) begin
			// plain append at tail
			rows_next[tail[`TAG_BITS-1:0]] = bh_row;
			tail_next = tail + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			tail <= '0;
		end else begin
			tail <= tail_next;
		end
	end

	// queue rows
	always_ff @(posedge clock) begin
		rows <= rows_next;
	end

endmodule

/* hw/pht_ram.sv */
`timescale 1ns/10ps
`include "bp_consts.svh"

module pht_ram (
	input  logic       clock,
	input  logic       reset,
	pht_bus_if.arbiter bus
);

	bp_pkg::ctr_t             mem [`PHT_ENTRIES];
	logic [`PHT_IDX_BITS-1:0] init_idx;
	logic                     ready;

	// no grant until the init walk is done
	assign bus.gnt = bus.req & ready;

	// after reset, walk one entry per cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			init_idx <= '0;
			ready    <= 1'b0;
		end else if (!ready) begin
			init_idx <= init_idx + 1'b1;
			ready    <= (init_idx == `PHT_IDX_BITS'(`PHT_ENTRIES - 1));
		end
	end

	always_ff @(posedge clock) begin
		if (!ready) begin
			// every counter starts weakly not taken
			mem[init_idx] <= bp_pkg::CTR_WNT;
		end else if (bus.req && bus.we) begin
			mem[bus.addr] <= bus.wdata;
		end
		// registered read, valid the cycle after the access
		if (bus.gnt && !bus.we) begin
			bus.rdata <= mem[bus.addr];
		end
	end

endmodule

/* hw/pht_arbiter.sv */
`timescale 1ns/10ps

// fixed priority, resolve wins over lookup
module pht_arbiter (
	input  logic         clock,
	input  logic         reset,
	pht_bus_if.arbiter   lookup_bus,
	pht_bus_if.arbiter   resolve_bus,
	pht_bus_if.requester mem_bus
);

	bp_pkg::grant_t sel;
	bp_pkg::grant_t last_gnt;

	always_comb begin
		if (resolve_bus.req) begin
			sel = bp_pkg::GNT_RESOLVE;
		end else if (lookup_bus.req) begin
			sel = bp_pkg::GNT_LOOKUP;
		end else begin
			sel = bp_pkg::GNT_NONE;
		end
	end

	// forward the selected request to the table
	assign mem_bus.req   = (sel != bp_pkg::GNT_NONE);
	assign mem_bus.we    = (sel == bp_pkg::GNT_RESOLVE) ? resolve_bus.we : lookup_bus.we;
	assign mem_bus.addr  = (sel == bp_pkg::GNT_RESOLVE) ? resolve_bus.addr : lookup_bus.addr;
	assign mem_bus.wdata = (sel == bp_pkg::GNT_RESOLVE) ? resolve_bus.wdata : lookup_bus.wdata;

	// table grant passes through to the owner only
	assign resolve_bus.gnt = mem_bus.gnt & (sel == bp_pkg::GNT_RESOLVE);
	assign lookup_bus.gnt  = mem_bus.gnt & (sel == bp_pkg::GNT_LOOKUP);

	// who got the port last cycle owns this cycle's read data
	always_ff @(posedge clock) begin
		if (reset) begin
			last_gnt <= bp_pkg::GNT_NONE;
		end else begin
			last_gnt <= mem_bus.gnt ? sel : bp_pkg::GNT_NONE;
		end
	end

	assign resolve_bus.rdata = (last_gnt == bp_pkg::GNT_RESOLVE) ? mem_bus.rdata : bp_pkg::CTR_WNT;
	assign lookup_bus.rdata  = (last_gnt == bp_pkg::GNT_LOOKUP) ? mem_bus.rdata : bp_pkg::CTR_WNT;

endmodule

/* hw/bp_lookup.sv */
`timescale 1ns/10ps
`include "bp_consts.svh"

module bp_lookup (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  fetch_valid,
	input  logic [`PC_BITS-1:0]   fetch_pc,
	output logic                  fetch_ready,
	output logic                  pred_valid,
	output logic                  pred_taken,
	output logic [`TAG_BITS-1:0]  pred_tag,
	pht_bus_if.requester          bus,
	output logic                  q_write_en,
	output bp_pkg::obq_row_t      q_row,
	input  logic [`TAG_BITS:0]    q_tail,
	input  logic                  q_full,
	input  logic                  q_busy,
	input  logic                  repair_valid,
	input  logic [`GHR_BITS-1:0]  repair_ghr
);

	logic [`GHR_BITS-1:0]     ghr;
	logic [`PHT_IDX_BITS-1:0] idx_q;
	logic                     req_pend;
	logic                     data_pend;
	logic                     hold_valid;
	logic                     hold_taken;
	logic                     cur_taken;
	logic                     append_ok;

	// one fetch in flight, and never while the queue is full or being rolled back
	assign fetch_ready = !(req_pend || data_pend || hold_valid) && !q_full && !q_busy;

	// read-only requester
	assign bus.req   = req_pend;
	assign bus.we    = 1'b0;
	assign bus.addr  = idx_q;
	assign bus.wdata = bp_pkg::CTR_WNT;

	// counter msb is the direction, or the held one if the queue was busy
	assign cur_taken = hold_valid ? hold_taken : bus.rdata[1];
	assign append_ok = (data_pend || hold_valid) && !q_busy;

	// prediction and append happen in the same cycle, tag is the tail slot
	assign pred_valid = append_ok;
	assign pred_taken = cur_taken;
	assign pred_tag   = q_tail[`TAG_BITS-1:0];
	assign q_write_en = append_ok;
	assign q_row      = '{ghr: ghr, idx: idx_q, taken: cur_taken};

	always_ff @(posedge clock) begin
		if (reset) begin
			ghr        <= '0;
			req_pend   <= 1'b0;
			data_pend  <= 1'b0;
			hold_valid <= 1'b0;
		end else begin
			if (fetch_valid && fetch_ready) begin
				req_pend <= 1'b1;
			end else if (req_pend && bus.gnt) begin
				req_pend <= 1'b0;
			end
			data_pend <= req_pend && bus.gnt;
			// queue taken by a rollback or flush, keep the answer for later
			if (data_pend && q_busy) begin
				hold_valid <= 1'b1;
			end else if (hold_valid && !q_busy) begin
				hold_valid <= 1'b0;
			end
			// a repair overrides the speculative shift
			if (repair_valid) begin
				ghr <= repair_ghr;
			end else if (append_ok) begin
				ghr <= {ghr[`GHR_BITS-2:0], cur_taken};
			end
		end
	end

	always_ff @(posedge clock) begin
		// gshare hash, pc word address xor history
		if (fetch_valid && fetch_ready) begin
			idx_q <= fetch_pc[`PHT_IDX_BITS+1:2] ^ ghr;
		end
		if (data_pend) begin
			hold_taken <= bus.rdata[1];
		end
	end

endmodule

/* hw/bp_resolve.sv */
`timescale 1ns/10ps
`include "bp_consts.svh"

module bp_resolve (
	input  logic                               clock,
	input  logic                               reset,
	input  logic                               resolve_valid,
	input  logic [`TAG_BITS-1:0]               resolve_tag,
	input  logic                               resolve_taken,
	output logic                               resolve_ready,
	pht_bus_if.requester                       bus,
	input  bp_pkg::obq_row_t [`OBQ_DEPTH-1:0]  q_rows,
	output logic                               q_clear_en,
	output logic                               q_write_en,
	output logic [`TAG_BITS-1:0]               q_index,
	output bp_pkg::obq_row_t                   q_row,
	output logic                               repair_valid,
	output logic [`GHR_BITS-1:0]               repair_ghr
);

	bp_pkg::res_state_t state;
	bp_pkg::obq_row_t   row_q;
	logic [`TAG_BITS-1:0] tag_q;
	logic               taken_q;
	logic               mispredict;
	logic               rollback;

	// saturating step toward the outcome
	function automatic bp_pkg::ctr_t step_ctr(input bp_pkg::ctr_t c, input logic up);
		bp_pkg::ctr_t n;
		n = c;
		if (up && c != bp_pkg::CTR_ST) begin
			n = bp_pkg::ctr_t'(c + 2'd1);
		end else if (!up && c != bp_pkg::CTR_SNT) begin
			n = bp_pkg::ctr_t'(c - 2'd1);
		end
		return n;
	endfunction

	assign resolve_ready = (state == bp_pkg::RES_IDLE);

	// read in RES_READ, write back in RES_WRITE with the fresh read data
	assign bus.req   = (state != bp_pkg::RES_IDLE);
	assign bus.we    = (state == bp_pkg::RES_WRITE);
	assign bus.addr  = row_q.idx;
	assign bus.wdata = step_ctr(bus.rdata, taken_q);

	// rollback goes out together with the counter write
	assign mispredict = (row_q.taken != taken_q);
	assign rollback   = (state == bp_pkg::RES_WRITE) && bus.gnt && mispredict;

	assign q_clear_en   = rollback;
	assign q_write_en   = rollback;
	assign q_index      = tag_q;
	assign q_row        = '{ghr: row_q.ghr, idx: row_q.idx, taken: taken_q};
	assign repair_valid = rollback;
	assign repair_ghr   = {row_q.ghr[`GHR_BITS-2:0], taken_q};

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= bp_pkg::RES_IDLE;
		end else begin
			case (state)
				bp_pkg::RES_IDLE:  if (resolve_valid) state <= bp_pkg::RES_READ;
				bp_pkg::RES_READ:  if (bus.gnt) state <= bp_pkg::RES_WRITE;
				bp_pkg::RES_WRITE: if (bus.gnt) state <= bp_pkg::RES_IDLE;
				default:           state <= bp_pkg::RES_IDLE;
			endcase
		end
	end

	// snapshot the branch's row at the handshake
	always_ff @(posedge clock) begin
		if (resolve_valid && resolve_ready) begin
			row_q   <= q_rows[resolve_tag];
			tag_q   <= resolve_tag;
			taken_q <= resolve_taken;
		end
	end

endmodule

/* hw/branch_pred_top.sv */
`timescale 1ns/10ps
`include "bp_consts.svh"

module branch_pred_top (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 fetch_valid,
	input  logic [`PC_BITS-1:0]  fetch_pc,
	output logic                 fetch_ready,
	output logic                 pred_valid,
	output logic                 pred_taken,
	output logic [`TAG_BITS-1:0] pred_tag,
	input  logic                 resolve_valid,
	input  logic [`TAG_BITS-1:0] resolve_tag,
	input  logic                 resolve_taken,
	output logic                 resolve_ready,
	input  logic                 flush,
	output logic                 hist_valid,
	output logic                 hist_newest_taken
);

	pht_bus_if lookup_bus ();
	pht_bus_if resolve_bus ();
	pht_bus_if mem_bus ();

	bp_pkg::obq_row_t [`OBQ_DEPTH-1:0] q_rows;
	bp_pkg::obq_row_t     bh_pred;
	bp_pkg::obq_row_t     look_row;
	bp_pkg::obq_row_t     res_row;
	logic [`TAG_BITS:0]   q_tail;
	logic [`TAG_BITS-1:0] res_index;
	logic                 q_full;
	logic                 look_write;
	logic                 res_write;
	logic                 res_clear;
	logic                 res_repair;
	logic [`GHR_BITS-1:0] res_ghr;

	// flush clears the whole queue and zeroes the history
	obq obq_inst (
		.clock, .reset,
		.write_en(look_write | (res_write & ~flush)),
		.clear_en(res_clear | flush),
		.index(flush ? '0 : res_index),
		.bh_row(res_write ? res_row : look_row),
		.tail(q_tail), .bh_pred_valid(hist_valid), .bh_pred, .full(q_full), .rows(q_rows)
	);

	assign hist_newest_taken = bh_pred.taken;

	pht_ram pht_ram_inst (.clock, .reset, .bus(mem_bus));

	pht_arbiter pht_arbiter_inst (.clock, .reset, .lookup_bus, .resolve_bus, .mem_bus);

	bp_lookup bp_lookup_inst (
		.clock, .reset, .fetch_valid, .fetch_pc, .fetch_ready,
		.pred_valid, .pred_taken, .pred_tag, .bus(lookup_bus),
		.q_write_en(look_write), .q_row(look_row), .q_tail, .q_full,
		.q_busy(res_clear | flush),
		.repair_valid(res_repair | flush),
		.repair_ghr(flush ? '0 : res_ghr)
	);

	bp_resolve bp_resolve_inst (
		.clock, .reset, .resolve_valid, .resolve_tag, .resolve_taken, .resolve_ready,
		.bus(resolve_bus), .q_rows,
		.q_clear_en(res_clear), .q_write_en(res_write), .q_index(res_index), .q_row(res_row),
		.repair_valid(res_repair), .repair_ghr(res_ghr)
	);

endmodule

/* dv/branch_pred_chk.sv */
`timescale 1ns/10ps

module branch_pred_chk (
	input logic clock,
	input logic reset,
	input logic fetch_valid,
	input logic fetch_ready,
	input logic pred_valid,
	input logic resolve_valid,
	input logic resolve_ready,
	input logic flush,
	input logic hist_valid,
	input logic q_full
);

	int   fail_count = 0;
	logic fetch_open;

	// a fetch was accepted and its prediction has not come out yet
	always_ff @(posedge clock) begin
		if (reset) begin
			fetch_open <= 1'b0;
		end else if (fetch_valid && fetch_ready) begin
			fetch_open <= 1'b1;
		end else if (pred_valid) begin
			fetch_open <= 1'b0;
		end
	end

	pred_not_full: assert property (@(posedge clock) disable iff (reset)
		pred_valid |-> !q_full)
		else begin
			fail_count++;
			$error("prediction issued while the queue is full");
		end

	// exactly one prediction per accepted fetch
	pred_once: assert property (@(posedge clock) disable iff (reset)
		pred_valid |-> fetch_open)
		else begin
			fail_count++;
			$error("prediction without an open fetch");
		end

	fetch_single: assert property (@(posedge clock) disable iff (reset)
		fetch_valid && fetch_ready |=> !fetch_ready)
		else begin
			fail_count++;
			$error("second fetch accepted while one is in flight");
		end

	resolve_single: assert property (@(posedge clock) disable iff (reset)
		resolve_valid && resolve_ready |=> !resolve_ready)
		else begin
			fail_count++;
			$error("second resolve accepted while one is in flight");
		end

	// flush empties the queue on the next edge
	flush_empties: assert property (@(posedge clock) disable iff (reset)
		flush |=> !hist_valid)
		else begin
			fail_count++;
			$error("queue not empty after flush");
		end

endmodule

bind branch_pred_top branch_pred_chk branch_pred_chk_inst (
	.clock, .reset, .fetch_valid, .fetch_ready, .pred_valid,
	.resolve_valid, .resolve_ready, .flush, .hist_valid, .q_full
);

/* dv/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
	output logic clock,
	output logic reset
);

	// 8 ns period
	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// reset held over the first two rising edges
	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

/* dv/tb_top.sv */
`timescale 1ns/10ps
`include "bp_consts.svh"

module tb_top;

	// rough cycle cost per test with the table init walk in the first
	localparam int CYCLE_LIMIT = 4 * (110 + 70 + 90 + 50 + 80 + 30);

	logic                 clock;
	logic                 reset;
	logic                 fetch_valid;
	logic [`PC_BITS-1:0]  fetch_pc;
	logic                 fetch_ready;
	logic                 pred_valid;
	logic                 pred_taken;
	logic [`TAG_BITS-1:0] pred_tag;
	logic                 resolve_valid;
	logic [`TAG_BITS-1:0] resolve_tag;
	logic                 resolve_taken;
	logic                 resolve_ready;
	logic                 flush;
	logic                 hist_valid;
	logic                 hist_newest_taken;

	// reference model of history, tail, counters and queue rows
	logic [`GHR_BITS-1:0]     m_ghr;
	int                       m_tail;
	int                       m_ctr [`PHT_ENTRIES];
	logic [`GHR_BITS-1:0]     m_row_ghr [`OBQ_DEPTH];
	logic [`PHT_IDX_BITS-1:0] m_row_idx [`OBQ_DEPTH];
	logic                     m_row_taken [`OBQ_DEPTH];

	int errors = 0;
	int checks = 0;
	int tests_failed = 0;
	int err_mark = 0;
	int cycle_count = 0;

	tb_clock tb_clock_inst (.clock, .reset);

	branch_pred_top branch_pred_top_inst (.*);

	// own checks plus failures of the bound assertions
	function automatic int total_errors();
		return errors + branch_pred_top_inst.branch_pred_chk_inst.fail_count;
	endfunction

	task automatic expect_equal(input int got, input int want, input string what);
		checks++;
		assert (got == want) else begin
			errors++;
			$display("[FAIL] %0t %s is %0d, expected %0d", $time, what, got, want);
		end
	endtask

	task automatic report_test(input int num, input string name);
		if (total_errors() == err_mark) begin
			$display("test %0d %s: pass", num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: fail, %0d errors", num, name, total_errors() - err_mark);
		end
		err_mark = total_errors();
	endtask

	// one fetch with its prediction checked against the model
	task automatic fetch_branch(input logic [`PC_BITS-1:0] pc, output logic taken, output int tag);
		logic [`PHT_IDX_BITS-1:0] idx;
		logic [`GHR_BITS-1:0]     ghr_at;
		logic                     want;
		@(posedge clock);
		fetch_valid <= 1'b1;
		fetch_pc    <= pc;
		@(negedge clock);
		while (!fetch_ready) @(negedge clock);
		// gshare index from the history seen at the handshake
		ghr_at = m_ghr;
		idx    = pc[`PHT_IDX_BITS+1:2] ^ ghr_at;
		@(posedge clock);
		fetch_valid <= 1'b0;
		@(negedge clock);
		while (!pred_valid) @(negedge clock);
		want  = (m_ctr[idx] >= 2);
		taken = pred_taken;
		tag   = int'(pred_tag);
		expect_equal(int'(pred_taken), int'(want), "pred_taken");
		expect_equal(tag, m_tail, "pred_tag");
		m_row_ghr[m_tail]   = ghr_at;
		m_row_idx[m_tail]   = idx;
		m_row_taken[m_tail] = want;
		m_tail++;
		m_ghr = {m_ghr[`GHR_BITS-2:0], want};
	endtask

	// resolve and train the model counter, rolling back on mispredict
	task automatic resolve_branch(input logic [`TAG_BITS-1:0] tag, input logic actual);
		logic [`PHT_IDX_BITS-1:0] idx;
		logic                     miss;
		@(posedge clock);
		resolve_valid <= 1'b1;
		resolve_tag   <= tag;
		resolve_taken <= actual;
		@(negedge clock);
		while (!resolve_ready) @(negedge clock);
		@(posedge clock);
		resolve_valid <= 1'b0;
		idx  = m_row_idx[tag];
		miss = (m_row_taken[tag] != actual);
		if (actual && m_ctr[idx] < 3) begin
			m_ctr[idx]++;
		end else if (!actual && m_ctr[idx] > 0) begin
			m_ctr[idx]--;
		end
		if (miss) begin
			m_tail           = int'(tag) + 1;
			m_row_taken[tag] = actual;
			m_ghr            = {m_row_ghr[tag][`GHR_BITS-2:0], actual};
		end
		@(negedge clock);
		while (!resolve_ready) @(negedge clock);
		if (miss) begin
			// rewritten row is now the newest
			expect_equal(int'(hist_valid), 1, "hist_valid after rollback");
			expect_equal(int'(hist_newest_taken), int'(actual), "hist_newest_taken");
		end
	endtask

	task automatic flush_queue();
		@(posedge clock);
		flush <= 1'b1;
		@(posedge clock);
		flush <= 1'b0;
		m_ghr  = '0;
		m_tail = 0;
		@(negedge clock);
		expect_equal(int'(hist_valid), 0, "hist_valid after flush");
	endtask

	// run limit
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: run passed %0d cycles, a handshake never completed", CYCLE_LIMIT);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		logic [`PC_BITS-1:0] pc_a;
		logic [`PC_BITS-1:0] pc_b;
		logic                got_taken;
		int                  got_tag;
		int                  t6_tag;
		fetch_valid   = 1'b0;
		fetch_pc      = '0;
		resolve_valid = 1'b0;
		resolve_tag   = '0;
		resolve_taken = 1'b0;
		flush         = 1'b0;
		void'($urandom(60));
		m_ghr  = '0;
		m_tail = 0;
		// every counter leaves reset weakly not taken
		for (int i = 0; i < `PHT_ENTRIES; i++) begin
			m_ctr[i] = 1;
		end
		@(negedge clock);
		while (reset) @(negedge clock);

		for (int i = 0; i < 4; i++) begin
			fetch_branch($urandom, got_taken, got_tag);
			expect_equal(int'(got_taken), 0, "first prediction");
			expect_equal(got_tag, i, "tag order");
		end
		report_test(1, "reset predictions");

		// two taken resolves lift the counter to strong taken
		flush_queue();
		pc_a = $urandom;
		fetch_branch(pc_a, got_taken, got_tag);
		resolve_branch(3'd0, 1'b1);
		resolve_branch(3'd0, 1'b1);
		flush_queue();
		fetch_branch(pc_a, got_taken, got_tag);
		expect_equal(int'(got_taken), 1, "taken after training");
		// after saturating low a single taken only reaches weakly not taken
		pc_b = pc_a + 32'd4;
		flush_queue();
		fetch_branch(pc_b, got_taken, got_tag);
		repeat (3) resolve_branch(3'd0, 1'b0);
		resolve_branch(3'd0, 1'b1);
		flush_queue();
		fetch_branch(pc_b, got_taken, got_tag);
		expect_equal(int'(got_taken), 0, "saturated counter");
		report_test(2, "counter training");

		flush_queue();
		repeat (`OBQ_DEPTH) fetch_branch($urandom, got_taken, got_tag);
		@(negedge clock);
		expect_equal(int'(fetch_ready), 0, "fetch_ready when full");
		@(posedge clock);
		fetch_valid <= 1'b1;
		repeat (10) begin
			@(negedge clock);
			expect_equal(int'(pred_valid), 0, "pred_valid when full");
		end
		@(posedge clock);
		fetch_valid <= 1'b0;
		flush_queue();
		fetch_branch($urandom, got_taken, got_tag);
		expect_equal(got_tag, 0, "tag after flush");
		report_test(3, "queue full");

		flush_queue();
		repeat (4) fetch_branch($urandom, got_taken, got_tag);
		resolve_branch(3'd1, !m_row_taken[1]);
		fetch_branch($urandom, got_taken, got_tag);
		expect_equal(got_tag, 2, "tag after rollback");
		report_test(4, "rollback");

		// B's own slot predicts not taken while B with history 1 is trained taken
		do begin
			pc_b = $urandom;
		end while (m_ctr[pc_b[`PHT_IDX_BITS+1:2]] >= 2);
		flush_queue();
		fetch_branch(pc_b ^ 32'h4, got_taken, got_tag);
		resolve_branch(3'd0, 1'b1);
		resolve_branch(3'd0, 1'b1);
		do begin
			pc_a = $urandom;
		end while (m_ctr[pc_a[`PHT_IDX_BITS+1:2]] >= 2 ||
			pc_a[`PHT_IDX_BITS+1:2] == pc_b[`PHT_IDX_BITS+1:2]);
		flush_queue();
		fetch_branch(pc_a, got_taken, got_tag);
		resolve_branch(3'd0, 1'b1);
		fetch_branch(pc_b, got_taken, got_tag);
		expect_equal(int'(got_taken), 1, "prediction from repaired history");
		report_test(5, "history repair");

		flush_queue();
		fetch_branch($urandom, got_taken, got_tag);
		// concurrent fetch must not share the counter being trained
		do begin
			pc_a = $urandom;
		end while ((pc_a[`PHT_IDX_BITS+1:2] ^ m_ghr) == m_row_idx[0]);
		fork
			begin
				fetch_branch(pc_a, got_taken, t6_tag);
				// resolve wins the table and is idle again when the prediction shows
				expect_equal(int'(resolve_ready), 1, "resolve_ready at prediction");
			end
			resolve_branch(3'd0, m_row_taken[0]);
		join
		expect_equal(t6_tag, 1, "concurrent tag");
		report_test(6, "concurrent fetch and resolve");

		$display("summary: tests 6, failed %0d, checks %0d, errors %0d",
			tests_failed, checks, total_errors());
		if (total_errors() == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+hw
hw/bp_pkg.sv
hw/pht_bus_if.sv
hw/obq.sv
hw/pht_ram.sv
hw/pht_arbiter.sv
hw/bp_lookup.sv
hw/bp_resolve.sv
hw/branch_pred_top.sv
dv/branch_pred_chk.sv
dv/tb_clock.sv
dv/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIMFLAGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIMFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "No errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
